// ==== tb.f ====
+incdir+src
src/keyboard_pkg.sv
src/key_debouncer.sv
src/mode_controller.sv
src/song_browser.sv
src/tube_text.sv
src/keyboard_menu_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the keyboard menu testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps
`include "keyboard_defines.svh"

module tb_top;

	localparam int HOLD = 3 * `DEBOUNCE_CYCLES;

	logic                     slow_clk;
	logic                     rst_n;
	logic                     center;
	logic                     up;
	logic                     down;
	logic                     left;
	logic                     right;
	logic                     esc_n;
	logic [7:0]               notes_n;
	logic                     press_stb;
	logic                     check_stb;
	logic                     check_done;
	int                       err_count;
	int                       check_count;
	int                       timeouts;
	integer                   seed;
	keyboard_pkg::mode_e      mode;
	keyboard_pkg::mode_e      cursor;
	keyboard_pkg::key_map_t   key_map;
	logic [2:0]               song_id;
	keyboard_pkg::tube_text_t text;
	logic                     tube_en;

	// 0 center, 1 up, 2 down, 3 left, 4 right, 5 esc, 6.. notes
	int directed [30] = '{0, 1, 0, 7, 6, 8, 9, 10, 11, 12, 2, 1, 0, 8, 9,
		10, 5, 3, 0, 4, 2, 3, 0, 1, 2, 3, 2, 0, 5, 5};
	int nav_pick [16] = '{0, 0, 0, 1, 1, 1, 2, 2, 2, 3, 3, 4, 4, 5, 5, 5};

	keyboard_menu_top u_keyboard_menu_top (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.center   (center),
		.up       (up),
		.down     (down),
		.left     (left),
		.right    (right),
		.esc_n    (esc_n),
		.notes_n  (notes_n),
		.mode     (mode),
		.cursor   (cursor),
		.key_map  (key_map),
		.song_id  (song_id),
		.text     (text),
		.tube_en  (tube_en)
	);

	tb_checker u_tb_checker (
		.slow_clk    (slow_clk),
		.rst_n       (rst_n),
		.center      (center),
		.up          (up),
		.down        (down),
		.left        (left),
		.right       (right),
		.esc_n       (esc_n),
		.notes_n     (notes_n),
		.press_stb   (press_stb),
		.check_stb   (check_stb),
		.mode        (mode),
		.cursor      (cursor),
		.key_map     (key_map),
		.song_id     (song_id),
		.text        (text),
		.tube_en     (tube_en),
		.check_done  (check_done),
		.err_count   (err_count),
		.check_count (check_count)
	);

	initial begin
		slow_clk = 1'b0;
		forever #50 slow_clk = ~slow_clk;
	end

	task automatic next_edge(input int n);
		repeat (n) @(posedge slow_clk);
		#1;
	endtask

	task automatic drive_button(input int btn, input logic on);
		case (btn)
			0: center = on;
			1: up = on;
			2: down = on;
			3: left = on;
			4: right = on;
			5: esc_n = ~on;             // Active low pins
			default: notes_n[3'(btn - 6)] = ~on;
		endcase
	endtask

	task automatic run_check();
		int waited;
		waited = 0;
		check_stb = 1'b1;
		next_edge(1);
		check_stb = 1'b0;
		while (!check_done && waited < 10) begin
			next_edge(1);
			waited++;
		end
		if (!check_done) begin
			$display("Timeout: the checker did not answer a compare request at %0t", $time);
			timeouts++;
		end
	endtask

	// Short holds model a bounce that must be filtered out
	task automatic press_button(input int btn, input int len, input logic real_press);
		drive_button(btn, 1'b1);
		press_stb = real_press;
		next_edge(1);
		press_stb = 1'b0;
		next_edge(len - 1);
		drive_button(btn, 1'b0);
		next_edge(HOLD);
		run_check();
	endtask

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < 20000) begin
			@(posedge slow_clk);
			cycles++;
		end
		$display("Timeout: the test did not finish within %0d clock cycles", cycles);
		$display("Something failed");
		$finish;
	end

	initial begin
		int r;
		int btn;
		seed      = 32'haaaa;
		rst_n     = 1'b0;
		center    = 1'b0;
		up        = 1'b0;
		down      = 1'b0;
		left      = 1'b0;
		right     = 1'b0;
		esc_n     = 1'b1;
		notes_n   = 8'hff;
		press_stb = 1'b0;
		check_stb = 1'b0;
		timeouts  = 0;
		next_edge(10);
		rst_n = 1'b1;
		next_edge(2);
		run_check();                    // Reset values
		foreach (directed[i])
			press_button(directed[i], HOLD, 1'b1);
		for (int step = 0; step < 300; step++) begin
			r = $unsigned($random(seed)) % 20;
			if (r < 16)
				btn = nav_pick[4'(r)];
			else
				btn = 6 + ($unsigned($random(seed)) % 8);
			if (($unsigned($random(seed)) % 8) == 0)
				press_button(btn, `DEBOUNCE_CYCLES - 1, 1'b0);
			else
				press_button(btn, HOLD, 1'b1);
		end
		$display("Checks: %0d  errors: %0d  timeouts: %0d", check_count, err_count, timeouts);
		if (err_count == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ps
`include "keyboard_defines.svh"

module tb_checker (
	input  logic                     slow_clk,
	input  logic                     rst_n,
	input  logic                     center,
	input  logic                     up,
	input  logic                     down,
	input  logic                     left,
	input  logic                     right,
	input  logic                     esc_n,
	input  logic [7:0]               notes_n,
	input  logic                     press_stb,
	input  logic                     check_stb,
	input  keyboard_pkg::mode_e      mode,
	input  keyboard_pkg::mode_e      cursor,
	input  keyboard_pkg::key_map_t   key_map,
	input  logic [2:0]               song_id,
	input  keyboard_pkg::tube_text_t text,
	input  logic                     tube_en,
	output logic                     check_done,
	output int                       err_count,
	output int                       check_count
);

	keyboard_pkg::mode_e    m_mode;
	keyboard_pkg::mode_e    m_cursor;
	keyboard_pkg::key_map_t m_map;
	keyboard_pkg::key_map_t m_pending;
	logic [2:0]             m_count;
	logic [2:0]             m_song;

	function automatic int find_button();
		int btn;
		btn = -1;
		if (center)
			btn = 0;
		else if (up)
			btn = 1;
		else if (down)
			btn = 2;
		else if (left)
			btn = 3;
		else if (right)
			btn = 4;
		else if (!esc_n)
			btn = 5;
		else
			for (int n = 0; n < 8; n++)
				if (!notes_n[3'(n)])
					btn = 6 + n;
		return btn;
	endfunction

	// Two columns of three, up walks down the column list
	function automatic keyboard_pkg::mode_e move_cursor(input keyboard_pkg::mode_e cur,
		input int btn);
		keyboard_pkg::mode_e grid [2][3];
		logic                col;
		logic [1:0]          row;
		grid = '{'{keyboard_pkg::free, keyboard_pkg::setting, keyboard_pkg::song_learn},
			'{keyboard_pkg::song_play, keyboard_pkg::ranking, keyboard_pkg::song_game}};
		col = 1'b0;
		row = 2'd0;
		for (int c = 0; c < 2; c++)
			for (int r = 0; r < 3; r++)
				if (grid[1'(c)][2'(r)] == cur) begin
					col = 1'(c);
					row = 2'(r);
				end
		if (btn == 1)
			row = (row == 2'd2) ? 2'd0 : row + 2'd1;
		else if (btn == 2)
			row = (row == 2'd0) ? 2'd2 : row - 2'd1;
		else
			col = ~col;
		return grid[col][row];
	endfunction

	// Song page and its active mode, both ways
	function automatic keyboard_pkg::mode_e partner_page(input keyboard_pkg::mode_e m);
		case (m)
			keyboard_pkg::song_play:  return keyboard_pkg::play;
			keyboard_pkg::song_learn: return keyboard_pkg::learn;
			keyboard_pkg::song_game:  return keyboard_pkg::game;
			keyboard_pkg::play:       return keyboard_pkg::song_play;
			keyboard_pkg::learn:      return keyboard_pkg::song_learn;
			keyboard_pkg::game:       return keyboard_pkg::song_game;
			default:                  return keyboard_pkg::choose;
		endcase
	endfunction

	function automatic keyboard_pkg::tube_text_t expected_text(input keyboard_pkg::mode_e m,
		input logic [2:0] song);
		logic [7:0] digits [8];
		digits = '{`TUB_1, `TUB_2, `TUB_3, `TUB_4, `TUB_5, `TUB_6, `TUB_7, `TUB_8};
		case (m)
			keyboard_pkg::welcome:
				return {`TUB_H, `TUB_E, `TUB_L, `TUB_L, `TUB_O, {3{`TUB_NIL}}};
			keyboard_pkg::choose:
				return {`TUB_C, `TUB_H, `TUB_O, `TUB_O, `TUB_S, `TUB_E, {2{`TUB_NIL}}};
			keyboard_pkg::song_play, keyboard_pkg::song_learn, keyboard_pkg::song_game,
			keyboard_pkg::play, keyboard_pkg::learn, keyboard_pkg::game:
				return {`TUB_S, `TUB_O, `TUB_N, `TUB_G, {2{`TUB_NIL}}, `TUB_0, digits[song]};
			default:
				return {8{`TUB_NIL}};
		endcase
	endfunction

	task automatic apply_press(input int btn);
		logic                song_page;
		keyboard_pkg::mode_e next_cur;
		song_page = m_mode inside {keyboard_pkg::song_play, keyboard_pkg::song_learn,
			keyboard_pkg::song_game};
		if (song_page && btn == 1)
			m_song[1:0] = m_song[1:0] - 2'd1;
		else if (song_page && btn == 2)
			m_song[1:0] = m_song[1:0] + 2'd1;
		else if (song_page && (btn == 3 || btn == 4))
			m_song[2] = ~m_song[2];
		case (m_mode)
			keyboard_pkg::welcome:
				if (btn == 0) begin
					m_mode   = keyboard_pkg::choose;
					m_cursor = keyboard_pkg::free;
				end
			keyboard_pkg::choose:
				if (btn == 0) begin
					if (m_cursor != keyboard_pkg::ranking)
						m_mode = m_cursor;  // Ranking entry does nothing
				end else if (btn == 5) begin
					m_mode = keyboard_pkg::welcome;
				end else if (btn >= 1 && btn <= 4) begin
					next_cur = move_cursor(m_cursor, btn);
					if (next_cur == keyboard_pkg::setting && m_cursor != keyboard_pkg::setting) begin
						m_pending = '0;
						m_count   = 3'd0;
					end
					m_cursor = next_cur;
				end
			keyboard_pkg::song_play, keyboard_pkg::song_learn, keyboard_pkg::song_game:
				if (btn == 0)
					m_mode = partner_page(m_mode);
				else if (btn == 5)
					m_mode = keyboard_pkg::choose;
			keyboard_pkg::free:
				if (btn == 5)
					m_mode = keyboard_pkg::choose;
			keyboard_pkg::play, keyboard_pkg::learn, keyboard_pkg::game:
				if (btn == 5)
					m_mode = partner_page(m_mode);
			keyboard_pkg::setting:
				if (btn == 5) begin
					m_mode = keyboard_pkg::choose;
				end else if (btn >= 6) begin
					m_pending[3'(btn - 6)] = m_count;
					m_count = m_count + 3'd1;
				end
			default: ;
		endcase
		// A complete map with a nonzero first entry is taken at once
		if (m_mode == keyboard_pkg::setting && m_count == 3'd7 && m_pending[0] != 3'd0) begin
			m_map  = m_pending;
			m_mode = keyboard_pkg::choose;
		end
	endtask

	task automatic compare_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		check_count++;
		if (exp !== act) begin
			err_count++;
			$display("CHECK FAILED at %0t: %s expected %h, actual %h", $time, name, exp, act);
		end
	endtask

	task automatic compare_outputs();
		logic en;
		en = m_mode inside {keyboard_pkg::free, keyboard_pkg::play, keyboard_pkg::learn,
			keyboard_pkg::game, keyboard_pkg::song_play, keyboard_pkg::song_learn,
			keyboard_pkg::song_game};
		compare_value("mode", 64'(m_mode), 64'(mode));
		compare_value("cursor", 64'(m_cursor), 64'(cursor));
		compare_value("key_map", 64'(m_map), 64'(key_map));
		compare_value("song_id", 64'(m_song), 64'(song_id));
		compare_value("text", 64'(expected_text(m_mode, m_song)), 64'(text));
		compare_value("tube_en", 64'(en), 64'(tube_en));
	endtask

	always @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			m_mode      = keyboard_pkg::welcome;
			m_cursor    = keyboard_pkg::free;
			m_pending   = '0;
			m_count     = 3'd0;
			m_song      = 3'd0;
			for (int i = 0; i < `NOTE_KEYS; i++)
				m_map[3'(i)] = 3'(i);
			err_count   = 0;
			check_count = 0;
			check_done <= 1'b0;
		end else begin
			if (press_stb)
				apply_press(find_button());
			if (check_stb)
				compare_outputs();
			check_done <= check_stb;
		end
	end

endmodule

// ==== src/keyboard_menu_top.sv ====
`timescale 1ns/1ps

module keyboard_menu_top (
	input  logic                     slow_clk,
	input  logic                     rst_n,
	input  logic                     center,
	input  logic                     up,
	input  logic                     down,
	input  logic                     left,
	input  logic                     right,
	input  logic                     esc_n,
	input  logic [7:0]               notes_n,
	output keyboard_pkg::mode_e      mode,
	output keyboard_pkg::mode_e      cursor,
	output keyboard_pkg::key_map_t   key_map,
	output logic [2:0]               song_id,
	output keyboard_pkg::tube_text_t text,
	output logic                     tube_en
);

	keyboard_pkg::key_event_u pressed;  // Held levels, kept for later engines
	keyboard_pkg::key_event_u pushed;

	key_debouncer u_key_debouncer (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.center   (center),
		.up       (up),
		.down     (down),
		.left     (left),
		.right    (right),
		.esc_n    (esc_n),
		.notes_n  (notes_n),
		.pressed  (pressed),
		.pushed   (pushed)
	);

	mode_controller u_mode_controller (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.pushed   (pushed),
		.mode     (mode),
		.cursor   (cursor),
		.key_map  (key_map)
	);

	song_browser u_song_browser (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.pushed   (pushed),
		.mode     (mode),
		.song_id  (song_id)
	);

	tube_text u_tube_text (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.mode     (mode),
		.song_id  (song_id),
		.text     (text),
		.tube_en  (tube_en)
	);

endmodule

// ==== src/tube_text.sv ====
`timescale 1ns/1ps
`include "keyboard_defines.svh"

module tube_text (
	input  logic                     slow_clk,
	input  logic                     rst_n,
	input  keyboard_pkg::mode_e      mode,
	input  logic [2:0]               song_id,
	output keyboard_pkg::tube_text_t text,
	output logic                     tube_en
);

	keyboard_pkg::tube_text_t text_nx;
	logic [7:0]               digit;
	logic                     en_nx;

	// Songs are shown counting from one
	always_comb begin
		case (song_id)
			3'd0:    digit = `TUB_1;
			3'd1:    digit = `TUB_2;
			3'd2:    digit = `TUB_3;
			3'd3:    digit = `TUB_4;
			3'd4:    digit = `TUB_5;
			3'd5:    digit = `TUB_6;
			3'd6:    digit = `TUB_7;
			default: digit = `TUB_8;
		endcase
	end

	always_comb begin
		case (mode)
			keyboard_pkg::welcome:
				text_nx = {`TUB_H, `TUB_E, `TUB_L, `TUB_L, `TUB_O, `TUB_NIL, `TUB_NIL, `TUB_NIL};
			keyboard_pkg::choose:
				text_nx = {`TUB_C, `TUB_H, `TUB_O, `TUB_O, `TUB_S, `TUB_E, `TUB_NIL, `TUB_NIL};
			keyboard_pkg::song_play, keyboard_pkg::song_learn, keyboard_pkg::song_game,
			keyboard_pkg::play, keyboard_pkg::learn, keyboard_pkg::game:
				text_nx = {`TUB_S, `TUB_O, `TUB_N, `TUB_G, `TUB_NIL, `TUB_NIL, `TUB_0, digit};
			default:
				text_nx = {8{`TUB_NIL}};
		endcase
	end

	assign en_nx = mode inside {keyboard_pkg::free, keyboard_pkg::play, keyboard_pkg::learn,
		keyboard_pkg::game, keyboard_pkg::song_play, keyboard_pkg::song_learn,
		keyboard_pkg::song_game};

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			text    <= {`TUB_H, `TUB_E, `TUB_L, `TUB_L, `TUB_O, `TUB_NIL, `TUB_NIL, `TUB_NIL};
			tube_en <= 1'b0;
		end else begin
			text    <= text_nx;
			tube_en <= en_nx;
		end
	end

endmodule

// ==== src/song_browser.sv ====
`timescale 1ns/1ps
`include "keyboard_defines.svh"

module song_browser (
	input  logic                     slow_clk,
	input  logic                     rst_n,
	input  keyboard_pkg::key_event_u pushed,
	input  keyboard_pkg::mode_e      mode,
	output logic [2:0]               song_id
);

	localparam logic [1:0] LAST_SLOT = 2'(`SONGS_PER_PAGE - 1);

	logic       page;
	logic [1:0] slot;
	logic       in_song;

	assign in_song = mode inside {keyboard_pkg::song_play, keyboard_pkg::song_learn,
		keyboard_pkg::song_game};

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			page <= 1'b0;
			slot <= 2'd0;
		end else if (in_song) begin
			if (pushed.keys.up)
				slot <= (slot == 2'd0) ? LAST_SLOT : slot - 2'd1;
			else if (pushed.keys.down)
				slot <= (slot == LAST_SLOT) ? 2'd0 : slot + 2'd1;
			else if (pushed.keys.left || pushed.keys.right)
				page <= ~page;
		end
	end

	assign song_id = {page, slot};

	// Selection is frozen outside the song pages
	a_hold_outside: assert property (@(posedge slow_clk) disable iff (!rst_n)
		!in_song |=> $stable(song_id));

endmodule

// ==== src/mode_controller.sv ====
`timescale 1ns/1ps
`include "keyboard_defines.svh"

module mode_controller (
	input  logic                     slow_clk,
	input  logic                     rst_n,
	input  keyboard_pkg::key_event_u pushed,
	output keyboard_pkg::mode_e      mode,
	output keyboard_pkg::mode_e      cursor,
	output keyboard_pkg::key_map_t   key_map
);

	keyboard_pkg::key_map_t pending;
	keyboard_pkg::mode_e    cursor_nx;
	logic [2:0]             count;
	logic                   one_hot;

	assign one_hot = $onehot(pushed.raw);

	// Cursor grid, the song entries point at their song pages
	always_comb begin
		cursor_nx = cursor;
		if (pushed.keys.up) begin
			case (cursor)
				keyboard_pkg::free:       cursor_nx = keyboard_pkg::setting;
				keyboard_pkg::setting:    cursor_nx = keyboard_pkg::song_learn;
				keyboard_pkg::song_learn: cursor_nx = keyboard_pkg::free;
				keyboard_pkg::song_play:  cursor_nx = keyboard_pkg::ranking;
				keyboard_pkg::ranking:    cursor_nx = keyboard_pkg::song_game;
				keyboard_pkg::song_game:  cursor_nx = keyboard_pkg::song_play;
				default:                  cursor_nx = cursor;
			endcase
		end else if (pushed.keys.down) begin
			case (cursor)
				keyboard_pkg::free:       cursor_nx = keyboard_pkg::song_learn;
				keyboard_pkg::song_learn: cursor_nx = keyboard_pkg::setting;
				keyboard_pkg::setting:    cursor_nx = keyboard_pkg::free;
				keyboard_pkg::song_play:  cursor_nx = keyboard_pkg::song_game;
				keyboard_pkg::song_game:  cursor_nx = keyboard_pkg::ranking;
				keyboard_pkg::ranking:    cursor_nx = keyboard_pkg::song_play;
				default:                  cursor_nx = cursor;
			endcase
		end else if (pushed.keys.left || pushed.keys.right) begin
			case (cursor)
				keyboard_pkg::free:       cursor_nx = keyboard_pkg::song_play;
				keyboard_pkg::song_play:  cursor_nx = keyboard_pkg::free;
				keyboard_pkg::song_learn: cursor_nx = keyboard_pkg::song_game;
				keyboard_pkg::song_game:  cursor_nx = keyboard_pkg::song_learn;
				keyboard_pkg::setting:    cursor_nx = keyboard_pkg::ranking;
				keyboard_pkg::ranking:    cursor_nx = keyboard_pkg::setting;
				default:                  cursor_nx = cursor;
			endcase
		end
	end

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			mode    <= keyboard_pkg::welcome;
			cursor  <= keyboard_pkg::free;
			pending <= '0;
			count   <= 3'd0;
			for (int i = 0; i < `NOTE_KEYS; i++)
				key_map[i] <= 3'(i);        // Identity map
		end else if (mode == keyboard_pkg::setting && count == 3'd7 && pending[0] != 3'd0) begin
			key_map <= pending;             // Commit does not wait for a key
			mode    <= keyboard_pkg::choose;
		end else if (one_hot) begin
			case (mode)
				keyboard_pkg::welcome:
					if (pushed.keys.center) begin
						mode   <= keyboard_pkg::choose;
						cursor <= keyboard_pkg::free;
					end
				keyboard_pkg::choose: begin
					if (pushed.keys.center) begin
						if (cursor != keyboard_pkg::ranking)
							mode <= cursor;
					end else if (pushed.keys.esc) begin
						mode <= keyboard_pkg::welcome;
					end else begin
						cursor <= cursor_nx;
						if (cursor_nx == keyboard_pkg::setting && cursor != keyboard_pkg::setting) begin
							pending <= '0;
							count   <= 3'd0;
						end
					end
				end
				keyboard_pkg::song_play:
					if (pushed.keys.center)   mode <= keyboard_pkg::play;
					else if (pushed.keys.esc) mode <= keyboard_pkg::choose;
				keyboard_pkg::song_learn:
					if (pushed.keys.center)   mode <= keyboard_pkg::learn;
					else if (pushed.keys.esc) mode <= keyboard_pkg::choose;
				keyboard_pkg::song_game:
					if (pushed.keys.center)   mode <= keyboard_pkg::game;
					else if (pushed.keys.esc) mode <= keyboard_pkg::choose;
				keyboard_pkg::free:  if (pushed.keys.esc) mode <= keyboard_pkg::choose;
				keyboard_pkg::play:  if (pushed.keys.esc) mode <= keyboard_pkg::song_play;
				keyboard_pkg::learn: if (pushed.keys.esc) mode <= keyboard_pkg::song_learn;
				keyboard_pkg::game:  if (pushed.keys.esc) mode <= keyboard_pkg::song_game;
				keyboard_pkg::setting: begin
					if (pushed.keys.esc) begin
						mode <= keyboard_pkg::choose;
					end else if (pushed.keys.notes != '0) begin
						for (int i = 0; i < `NOTE_KEYS; i++)
							if (pushed.keys.notes[i])
								pending[i] <= count;
						count <= count + 3'd1;
					end
				end
				default: ;                  // Ranking page is never entered
			endcase
		end
	end

	a_mode_legal: assert property (@(posedge slow_clk) disable iff (!rst_n)
		mode inside {keyboard_pkg::welcome, keyboard_pkg::choose, keyboard_pkg::free,
			keyboard_pkg::play, keyboard_pkg::learn, keyboard_pkg::game,
			keyboard_pkg::setting, keyboard_pkg::song_play, keyboard_pkg::song_learn,
			keyboard_pkg::song_game, keyboard_pkg::ranking});

endmodule

// ==== src/key_debouncer.sv ====
`timescale 1ns/1ps
`include "keyboard_defines.svh"

module key_debouncer (
	input  logic                    slow_clk,
	input  logic                    rst_n,
	input  logic                    center,
	input  logic                    up,
	input  logic                    down,
	input  logic                    left,
	input  logic                    right,
	input  logic                    esc_n,
	input  logic [7:0]              notes_n,
	output keyboard_pkg::key_event_u pressed,
	output keyboard_pkg::key_event_u pushed
);

	localparam int KEYS  = `NAV_KEYS + `NOTE_KEYS;
	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`DEBOUNCE_CYCLES - 1);

	logic [KEYS-1:0]  raw;
	logic [KEYS-1:0]  level;
	logic [KEYS-1:0]  pulse;
	logic [CNT_W-1:0] cnt [KEYS];

	// Same bit order as key_fields_t
	assign raw = {center, up, down, left, right, ~esc_n, ~notes_n};

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			level <= '0;
			pulse <= '0;
			for (int i = 0; i < KEYS; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < KEYS; i++) begin
				pulse[i] <= 1'b0;
				if (raw[i] == level[i]) begin
					cnt[i] <= '0;           // Bounce restarts the count
				end else if (cnt[i] == CNT_MAX) begin
					cnt[i]   <= '0;
					level[i] <= raw[i];
					pulse[i] <= raw[i];     // Rising edge only
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign pressed.raw = level;
	assign pushed.raw  = pulse;

	// Pulse sits on a held level and lasts one cycle
	a_push_is_press: assert property (@(posedge slow_clk) disable iff (!rst_n)
		(pushed.raw != '0) |-> ((pushed.raw & ~pressed.raw) == '0)
			##1 ((pushed.raw & $past(pushed.raw)) == '0));

endmodule

// ==== src/keyboard_pkg.sv ====
`include "keyboard_defines.svh"

package keyboard_pkg;

	// Page and mode code, also shown on the LEDs
	typedef enum logic [7:0] {
		welcome    = 8'h00,
		choose     = 8'h01,
		free       = 8'h02,
		play       = 8'h03,
		learn      = 8'h04,
		game       = 8'h05,
		setting    = 8'h06,
		song_play  = 8'h07,
		song_learn = 8'h08,
		song_game  = 8'h09,
		ranking    = 8'h0a
	} mode_e;

	typedef struct packed {
		logic                   center;
		logic                   up;
		logic                   down;
		logic                   left;
		logic                   right;
		logic                   esc;
		logic [`NOTE_KEYS-1:0]  notes;
	} key_fields_t;

	// Raw view for one-hot tests, field view for decoding
	typedef union packed {
		logic [`NAV_KEYS+`NOTE_KEYS-1:0] raw;
		key_fields_t                     keys;
	} key_event_u;

	typedef logic [`NOTE_KEYS-1:0][2:0] key_map_t;

	// Index 7 is the leftmost digit
	typedef logic [7:0][7:0] tube_text_t;

endpackage

// ==== src/keyboard_defines.svh ====
`ifndef KEYBOARD_DEFINES_SVH
`define KEYBOARD_DEFINES_SVH

// Samples a button must hold before its level is taken
`define DEBOUNCE_CYCLES 4

`define NOTE_KEYS      8
`define NAV_KEYS       6
`define SONGS_PER_PAGE 4

// Segments a..g then dp, MSB first
`define TUB_H   8'h6e
`define TUB_E   8'h9e
`define TUB_L   8'h1c
`define TUB_O   8'hfc
`define TUB_C   8'h9c
`define TUB_S   8'hb6
`define TUB_N   8'hec
`define TUB_G   8'hbc
`define TUB_0   8'hfc
`define TUB_1   8'h60
`define TUB_2   8'hda
`define TUB_3   8'hf2
`define TUB_4   8'h66
`define TUB_5   8'hb6
`define TUB_6   8'hbe
`define TUB_7   8'he0
`define TUB_8   8'hfe
`define TUB_NIL 8'h00

`endif
